// ==== list.f ====
common/axi_pack_pkg.sv
logic/beat_fifo.sv
logic/aw_release_gate.sv
packer/burst_release_ctrl.sv
packer/write_burst_packer.sv
tests/packer_checker.sv
tests/tb_write_burst_packer.sv

// ==== Bender.yml ====
package:
  name: write_burst_packer

sources:
  # Shared package first
  - common/axi_pack_pkg.sv
  # Leaf blocks
  - logic/beat_fifo.sv
  - logic/aw_release_gate.sv
  - packer/burst_release_ctrl.sv
  # Top level
  - packer/write_burst_packer.sv
  - target: test
    files:
      - tests/packer_checker.sv
      - tests/tb_write_burst_packer.sv

// ==== tests/tb_write_burst_packer.sv ====
// Write burst packer testbench
// Sends a random mix of short, long and single-beat bursts with
// upstream pauses and downstream stalls, and random B traffic

module tb_write_burst_packer;

  import axi_pack_pkg::*;

  localparam int NBursts = 24;

  logic  clk_i = 1'b0;
  logic  rst_ni = 1'b0;
  int    seed = 17;
  id_t   slv_aw_id_i;
  addr_t slv_aw_addr_i;
  len_t  slv_aw_len_i;
  logic  slv_aw_valid_i, slv_aw_ready_o;
  data_t slv_w_data_i;
  strb_t slv_w_strb_i;
  logic  slv_w_last_i, slv_w_valid_i, slv_w_ready_o;
  id_t   slv_b_id_o, mst_aw_id_o, mst_b_id_i;
  resp_t slv_b_resp_o, mst_b_resp_i;
  logic  slv_b_valid_o, slv_b_ready_i;
  addr_t mst_aw_addr_o;
  len_t  mst_aw_len_o;
  logic  mst_aw_valid_o, mst_aw_ready_i;
  data_t mst_w_data_o;
  strb_t mst_w_strb_o;
  logic  mst_w_last_o, mst_w_valid_o, mst_w_ready_i;
  logic  mst_b_valid_i, mst_b_ready_o;
  len_t  lens [NBursts];
  int    stall_left = 0;
  int    total_err;

  always #10 clk_i = ~clk_i;

  write_burst_packer write_burst_packer_i (.*);

  packer_checker packer_checker_i (
    .clk_i, .rst_ni,
    .slv_aw_valid_i, .slv_aw_ready_i (slv_aw_ready_o),
    .slv_w_last_i, .slv_w_valid_i, .slv_w_ready_i (slv_w_ready_o),
    .mst_aw_id_i (mst_aw_id_o), .mst_aw_addr_i (mst_aw_addr_o),
    .mst_aw_len_i (mst_aw_len_o), .mst_aw_valid_i (mst_aw_valid_o), .mst_aw_ready_i,
    .mst_w_data_i (mst_w_data_o), .mst_w_strb_i (mst_w_strb_o),
    .mst_w_last_i (mst_w_last_o), .mst_w_valid_i (mst_w_valid_o), .mst_w_ready_i,
    .slv_b_id_i (slv_b_id_o), .slv_b_resp_i (slv_b_resp_o),
    .slv_b_valid_i (slv_b_valid_o), .slv_b_ready_i,
    .mst_b_id_i, .mst_b_resp_i, .mst_b_valid_i, .mst_b_ready_i (mst_b_ready_o)
  );

  // Downstream ready pattern with occasional long stalls and random B traffic
  always @(negedge clk_i) begin
    if (stall_left > 0) begin
      stall_left--;
      mst_w_ready_i <= 1'b0;
    end else if ({$random(seed)} % 16 == 0) begin
      stall_left = 5;
      mst_w_ready_i <= 1'b0;
    end else begin
      mst_w_ready_i <= ({$random(seed)} % 4 != 0);
    end
    mst_aw_ready_i <= ({$random(seed)} % 3 != 0);
    mst_b_id_i     <= id_t'($random(seed));
    mst_b_resp_i   <= resp_t'($random(seed));
    mst_b_valid_i  <= 1'($random(seed));
    slv_b_ready_i  <= 1'($random(seed));
  end

  task automatic send_aw_stream();
    for (int b = 0; b < NBursts; b++) begin
      @(negedge clk_i);
      slv_aw_id_i    = id_t'(b);
      slv_aw_addr_i  = addr_t'(32'h1000_0000 + b * 64);
      slv_aw_len_i   = lens[b];
      slv_aw_valid_i = 1'b1;
      do @(posedge clk_i); while (!slv_aw_ready_o);
    end
    @(negedge clk_i);
    slv_aw_valid_i = 1'b0;
  endtask

  task automatic send_w_stream();
    w_beat_t beat;
    for (int b = 0; b < NBursts; b++) begin
      for (int i = 0; i <= int'(lens[b]); i++) begin
        @(negedge clk_i);
        while ({$random(seed)} % 5 == 0) begin
          slv_w_valid_i = 1'b0;
          @(negedge clk_i);
        end
        beat = packer_checker_i.expected_beat(b, i, int'(lens[b]));
        {slv_w_data_i, slv_w_strb_i, slv_w_last_i} = beat;
        slv_w_valid_i = 1'b1;
        do @(posedge clk_i); while (!slv_w_ready_o);
      end
    end
    @(negedge clk_i);
    slv_w_valid_i = 1'b0;
  endtask

  initial begin
    int r;
    slv_aw_id_i = '0;
    slv_aw_addr_i = '0;
    slv_aw_len_i = '0;
    slv_aw_valid_i = 1'b0;
    slv_w_data_i = '0;
    slv_w_strb_i = '0;
    slv_w_last_i = 1'b0;
    slv_w_valid_i = 1'b0;
    slv_b_ready_i = 1'b0;
    mst_aw_ready_i = 1'b0;
    mst_w_ready_i = 1'b0;
    mst_b_id_i = '0;
    mst_b_resp_i = '0;
    mst_b_valid_i = 1'b0;
    // Mix of single-beat, short and longer-than-buffer bursts
    for (int b = 0; b < NBursts; b++) begin
      r = {$random(seed)} % 4;
      if (r == 0) lens[b] = 0;
      else if (r == 1) lens[b] = len_t'(BufDepth + {$random(seed)} % 6);
      else lens[b] = len_t'(1 + {$random(seed)} % 7);
      packer_checker_i.add_burst(id_t'(b), addr_t'(32'h1000_0000 + b * 64), lens[b]);
    end
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    fork
      send_aw_stream();
      send_w_stream();
    join_none
    wait (packer_checker_i.done || packer_checker_i.timed_out);
    repeat (2) @(negedge clk_i);
    packer_checker_i.report_results(total_err);
    if (total_err == 0 && packer_checker_i.done && !packer_checker_i.timed_out) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== tests/packer_checker.sv ====
// Write burst packer checker
// Watches the DUT ports, holds the expected AW and W streams and
// compares every downstream transfer, the packing rules, the
// buffer level, back-pressure behavior and the B feed-through

module packer_checker (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  slv_aw_valid_i,
  input logic                  slv_aw_ready_i,
  input logic                  slv_w_last_i,
  input logic                  slv_w_valid_i,
  input logic                  slv_w_ready_i,
  input axi_pack_pkg::id_t     mst_aw_id_i,
  input axi_pack_pkg::addr_t   mst_aw_addr_i,
  input axi_pack_pkg::len_t    mst_aw_len_i,
  input logic                  mst_aw_valid_i,
  input logic                  mst_aw_ready_i,
  input axi_pack_pkg::data_t   mst_w_data_i,
  input axi_pack_pkg::strb_t   mst_w_strb_i,
  input logic                  mst_w_last_i,
  input logic                  mst_w_valid_i,
  input logic                  mst_w_ready_i,
  input axi_pack_pkg::id_t     slv_b_id_i,
  input axi_pack_pkg::resp_t   slv_b_resp_i,
  input logic                  slv_b_valid_i,
  input logic                  slv_b_ready_i,
  input axi_pack_pkg::id_t     mst_b_id_i,
  input axi_pack_pkg::resp_t   mst_b_resp_i,
  input logic                  mst_b_valid_i,
  input logic                  mst_b_ready_i
);

  import axi_pack_pkg::*;

  id_t   exp_id   [64];
  addr_t exp_addr [64];
  len_t  exp_len  [64];
  int    n_bursts = 0;
  int    total_beats = 0;
  int    limit = 200;
  int    err [1:6];
  int    w_burst = 0, w_beat = 0, aw_cnt = 0, up_last = 0, started = 0;
  int    in_buf = 0, cycles = 0;
  int    aw_held = 0;
  logic  offered_first = 1'b0;
  logic  prev_stall = 1'b0;
  logic  done = 1'b0;
  logic  timed_out = 1'b0;
  w_beat_t prev_beat;

  initial begin
    for (int t = 1; t <= 6; t++) err[t] = 0;
  end

  // Data, strobe and last of beat i in burst b
  function automatic w_beat_t expected_beat(int b, int i, int len);
    data_t d;
    strb_t s;
    d = {b[7:0], i[7:0], ~b[7:0], 8'h5a ^ i[7:0]};
    s = (i == len) ? strb_t'(4'h1 << ((b + i) % 4)) : '1;
    return {d, s, (i == len)};
  endfunction

  // Registers one burst with its AW fields and widens the run limit
  task automatic add_burst(id_t id, addr_t addr, len_t len);
    exp_id[n_bursts]   = id;
    exp_addr[n_bursts] = addr;
    exp_len[n_bursts]  = len;
    n_bursts++;
    total_beats += int'(len) + 1;
    limit = total_beats * 4 + 200;
  endtask

  always @(posedge clk_i) begin : watch
    w_beat_t seen, exp;
    seen = {mst_w_data_i, mst_w_strb_i, mst_w_last_i};
    cycles++;
    if (cycles > limit && !done && !timed_out) begin
      timed_out = 1'b1;
      $display("Run stopped after %0d cycles without all bursts leaving", cycles);
    end
    if (rst_ni) begin
      // B must pass through unchanged
      if (slv_b_valid_i !== mst_b_valid_i || slv_b_id_i !== mst_b_id_i ||
          slv_b_resp_i !== mst_b_resp_i || mst_b_ready_i !== slv_b_ready_i) begin
        err[6]++;
        $display("Error at time %0t: B channel differs between the two sides", $time);
      end
      if (slv_w_ready_i !== (in_buf != BufDepth)) begin
        err[4]++;
        $display("Error at time %0t: slv_w_ready is %b with %0d beats buffered",
                 $time, slv_w_ready_i, in_buf);
      end
      if (prev_stall && (!mst_w_valid_i || seen !== prev_beat)) begin
        err[4]++;
        $display("Error at time %0t: stalled mst_w beat changed or dropped", $time);
      end
      if (mst_w_valid_i) begin
        if (w_burst >= n_bursts) begin
          err[1]++;
          $display("Error at time %0t: mst_w beat beyond the last burst", $time);
        end else if (!offered_first) begin
          offered_first = 1'b1;
          started++;
          if (exp_len[w_burst] < BufDepth && up_last <= w_burst) begin
            err[2]++;
            $display("Error at time %0t: burst %0d offered before its last beat came in",
                     $time, w_burst);
          end
        end
      end else if (offered_first && w_burst < n_bursts && exp_len[w_burst] < BufDepth) begin
        err[2]++;
        $display("Error at time %0t: mst_w_valid dropped inside burst %0d", $time, w_burst);
      end
      // The AW holding register takes a new address when empty or being emptied
      if (slv_aw_ready_i !== (aw_held == 0 || (mst_aw_valid_i && mst_aw_ready_i))) begin
        err[3]++;
        $display("Error at time %0t: slv_aw_ready is %b with %0d AW held",
                 $time, slv_aw_ready_i, aw_held);
      end
      if (mst_aw_valid_i && mst_aw_ready_i) begin
        if (aw_cnt >= n_bursts) begin
          err[3]++;
          $display("Error at time %0t: extra mst_aw transfer", $time);
        end else if (mst_aw_id_i !== exp_id[aw_cnt] || mst_aw_addr_i !== exp_addr[aw_cnt] ||
                     mst_aw_len_i !== exp_len[aw_cnt]) begin
          err[3]++;
          $display("Error at time %0t: mst_aw %0d is %h/%h/%h", $time, aw_cnt,
                   mst_aw_id_i, mst_aw_addr_i, mst_aw_len_i);
        end
        aw_cnt++;
        aw_held--;
        if (aw_cnt > started) begin
          err[3]++;
          $display("Error at time %0t: mst_aw ran ahead of its W burst", $time);
        end
      end
      if (slv_aw_valid_i && slv_aw_ready_i) begin
        aw_held++;
      end
      if (mst_w_valid_i && mst_w_ready_i && w_burst < n_bursts) begin
        exp = expected_beat(w_burst, w_beat, int'(exp_len[w_burst]));
        if (seen !== exp) begin
          if (exp_len[w_burst] == 0) err[5]++;
          else err[1]++;
          $display("Error at time %0t: burst %0d beat %0d is %h, expected %h",
                   $time, w_burst, w_beat, seen, exp);
        end
        in_buf--;
        if (exp[0]) begin
          w_burst++;
          w_beat = 0;
          offered_first = 1'b0;
        end else begin
          w_beat++;
        end
      end
      prev_stall = mst_w_valid_i && !mst_w_ready_i;
      prev_beat  = seen;
      if (slv_w_valid_i && slv_w_ready_i) begin
        in_buf++;
        if (slv_w_last_i) up_last++;
      end
      if (n_bursts > 0 && w_burst == n_bursts && aw_cnt == n_bursts) done = 1'b1;
    end
  end

  // One line per test and a closing line with the totals
  task automatic report_results(output int total_err);
    string names [1:6];
    int    passed;
    names = '{"W data integrity", "Packing", "AW ordering",
              "Long bursts and back-pressure", "Single-beat bursts", "B feed-through"};
    passed = 0;
    total_err = 0;
    for (int t = 1; t <= 6; t++) begin
      $display("Test %0d %s: %s (%0d errors)", t, names[t],
               (err[t] == 0 && done) ? "ok" : "FAILED", err[t]);
      if (err[t] == 0 && done) passed++;
      total_err += err[t];
    end
    $display("Checks: 6 tests, %0d passed, %0d failed, %0d errors, %0d of %0d bursts done",
             passed, 6 - passed, total_err, w_burst, n_bursts);
  endtask

endmodule

// ==== packer/write_burst_packer.sv ====
// AXI4 write burst packer
// Buffers upstream W beats and sends each burst downstream as
// back-to-back beats once it is complete. The matching AW is held
// until its burst starts to leave. B is passed straight through.

module write_burst_packer (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Upstream master side
  input  axi_pack_pkg::id_t     slv_aw_id_i,
  input  axi_pack_pkg::addr_t   slv_aw_addr_i,
  input  axi_pack_pkg::len_t    slv_aw_len_i,
  input  logic                  slv_aw_valid_i,
  output logic                  slv_aw_ready_o,
  input  axi_pack_pkg::data_t   slv_w_data_i,
  input  axi_pack_pkg::strb_t   slv_w_strb_i,
  input  logic                  slv_w_last_i,
  input  logic                  slv_w_valid_i,
  output logic                  slv_w_ready_o,
  output axi_pack_pkg::id_t     slv_b_id_o,
  output axi_pack_pkg::resp_t   slv_b_resp_o,
  output logic                  slv_b_valid_o,
  input  logic                  slv_b_ready_i,
  // Downstream slave side
  output axi_pack_pkg::id_t     mst_aw_id_o,
  output axi_pack_pkg::addr_t   mst_aw_addr_o,
  output axi_pack_pkg::len_t    mst_aw_len_o,
  output logic                  mst_aw_valid_o,
  input  logic                  mst_aw_ready_i,
  output axi_pack_pkg::data_t   mst_w_data_o,
  output axi_pack_pkg::strb_t   mst_w_strb_o,
  output logic                  mst_w_last_o,
  output logic                  mst_w_valid_o,
  input  logic                  mst_w_ready_i,
  input  axi_pack_pkg::id_t     mst_b_id_i,
  input  axi_pack_pkg::resp_t   mst_b_resp_i,
  input  logic                  mst_b_valid_i,
  output logic                  mst_b_ready_o
);

  import axi_pack_pkg::*;

  w_beat_t fifo_in, fifo_head;
  logic    fifo_push, fifo_pop, fifo_full, fifo_empty;
  logic    burst_release;

  assign fifo_in = {slv_w_data_i, slv_w_strb_i, slv_w_last_i};

  // Head split back into the W fields
  assign mst_w_data_o = fifo_head[WBeatWidth-1 -: DataWidth];
  assign mst_w_strb_o = fifo_head[DataWidth/8:1];
  assign mst_w_last_o = fifo_head[0];

  beat_fifo #(
    .Depth (BufDepth)
  ) beat_fifo_i (
    .clk_i,
    .rst_ni,
    .push_i  (fifo_push),
    .data_i  (fifo_in),
    .pop_i   (fifo_pop),
    .head_o  (fifo_head),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  burst_release_ctrl burst_release_ctrl_i (
    .clk_i,
    .rst_ni,
    .slv_w_valid_i   (slv_w_valid_i),
    .slv_w_last_i    (slv_w_last_i),
    .slv_w_ready_o   (slv_w_ready_o),
    .fifo_push_o     (fifo_push),
    .fifo_pop_o      (fifo_pop),
    .fifo_full_i     (fifo_full),
    .fifo_empty_i    (fifo_empty),
    .head_last_i     (fifo_head[0]),
    .mst_w_valid_o   (mst_w_valid_o),
    .mst_w_ready_i   (mst_w_ready_i),
    .burst_release_o (burst_release)
  );

  aw_release_gate aw_release_gate_i (
    .clk_i,
    .rst_ni,
    .slv_aw_id_i     (slv_aw_id_i),
    .slv_aw_addr_i   (slv_aw_addr_i),
    .slv_aw_len_i    (slv_aw_len_i),
    .slv_aw_valid_i  (slv_aw_valid_i),
    .slv_aw_ready_o  (slv_aw_ready_o),
    .burst_release_i (burst_release),
    .mst_aw_id_o     (mst_aw_id_o),
    .mst_aw_addr_o   (mst_aw_addr_o),
    .mst_aw_len_o    (mst_aw_len_o),
    .mst_aw_valid_o  (mst_aw_valid_o),
    .mst_aw_ready_i  (mst_aw_ready_i)
  );

  // Write responses
  assign slv_b_id_o    = mst_b_id_i;
  assign slv_b_resp_o  = mst_b_resp_i;
  assign slv_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = slv_b_ready_i;

endmodule

// ==== packer/burst_release_ctrl.sv ====
// Burst release controller
// Decides when buffered W beats drain downstream. A burst leaves
// once all its beats sit in the FIFO, or once the FIFO is full.
// It then leaves as back-to-back beats, and a pulse on
// burst_release_o marks the first beat of each burst on offer.

module burst_release_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic slv_w_valid_i,
  input  logic slv_w_last_i,
  output logic slv_w_ready_o,
  output logic fifo_push_o,
  output logic fifo_pop_o,
  input  logic fifo_full_i,
  input  logic fifo_empty_i,
  input  logic head_last_i,
  output logic mst_w_valid_o,
  input  logic mst_w_ready_i,
  output logic burst_release_o
);

  import axi_pack_pkg::*;

  typedef enum logic [1:0] {
    Hold,
    Drain,
    Single
  } state_e;

  state_e   state_q, state_d;
  buf_cnt_t compl_q, compl_d;
  logic     start_pend_q, start_pend_d;
  logic     last_pushed, last_popped;

  // Upstream side stalls only on a full buffer
  assign slv_w_ready_o = ~fifo_full_i;
  assign fifo_push_o   = slv_w_valid_i & slv_w_ready_o;
  assign fifo_pop_o    = mst_w_valid_o & mst_w_ready_i;

  assign last_pushed = fifo_push_o & slv_w_last_i;
  assign last_popped = fifo_pop_o & head_last_i;

  // Complete bursts currently in the FIFO
  always_comb begin
    compl_d = compl_q;
    if (last_pushed) compl_d = compl_d + buf_cnt_t'(1);
    if (last_popped) compl_d = compl_d - buf_cnt_t'(1);
  end

  always_comb begin
    state_d       = state_q;
    mst_w_valid_o = 1'b0;

    unique case (state_q)
      Hold: begin
        if (!fifo_empty_i && head_last_i) begin
          // Head is a whole single-beat burst
          mst_w_valid_o = 1'b1;
          if (!mst_w_ready_i) begin
            state_d = Single;
          end
        end else if (fifo_full_i || (!fifo_empty_i && compl_q != '0)) begin
          mst_w_valid_o = 1'b1;
          state_d       = Drain;
        end
      end
      Drain: begin
        // Runs dry only while a long burst refills the buffer
        mst_w_valid_o = ~fifo_empty_i;
        if (last_popped && compl_d == '0) begin
          state_d = Hold;
        end
      end
      Single: begin
        mst_w_valid_o = 1'b1;
        if (mst_w_ready_i) begin
          state_d = Hold;
        end
      end
      default: begin
        state_d = Hold;
      end
    endcase
  end

  // The next offered beat opens a new burst until it has been announced
  assign burst_release_o = mst_w_valid_o & start_pend_q;

  always_comb begin
    start_pend_d = start_pend_q;
    if (last_popped) begin
      start_pend_d = 1'b1;
    end else if (burst_release_o) begin
      start_pend_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= Hold;
      compl_q      <= '0;
      start_pend_q <= 1'b1;
    end else begin
      state_q      <= state_d;
      compl_q      <= compl_d;
      start_pend_q <= start_pend_d;
    end
  end

endmodule

// ==== logic/aw_release_gate.sv ====
// AW release gate
// Holds one write address and lets it go downstream only after
// a W burst has started to leave the packer. Released bursts are
// counted as credits, each downstream AW consumes one.

module aw_release_gate (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  axi_pack_pkg::id_t   slv_aw_id_i,
  input  axi_pack_pkg::addr_t slv_aw_addr_i,
  input  axi_pack_pkg::len_t  slv_aw_len_i,
  input  logic                slv_aw_valid_i,
  output logic                slv_aw_ready_o,
  input  logic                burst_release_i,
  output axi_pack_pkg::id_t   mst_aw_id_o,
  output axi_pack_pkg::addr_t mst_aw_addr_o,
  output axi_pack_pkg::len_t  mst_aw_len_o,
  output logic                mst_aw_valid_o,
  input  logic                mst_aw_ready_i
);

  import axi_pack_pkg::*;

  id_t      id_q;
  addr_t    addr_q;
  len_t     len_q;
  logic     full_q;
  buf_cnt_t credit_q, credit_d;
  logic     aw_in, aw_out;

  // A release in this cycle counts as a credit right away
  assign mst_aw_valid_o = full_q & ((credit_q != '0) | burst_release_i);
  assign aw_out         = mst_aw_valid_o & mst_aw_ready_i;
  assign slv_aw_ready_o = ~full_q | aw_out;
  assign aw_in          = slv_aw_valid_i & slv_aw_ready_o;

  assign mst_aw_id_o   = id_q;
  assign mst_aw_addr_o = addr_q;
  assign mst_aw_len_o  = len_q;

  always_comb begin
    credit_d = credit_q;
    if (burst_release_i) credit_d = credit_d + buf_cnt_t'(1);
    if (aw_out)          credit_d = credit_d - buf_cnt_t'(1);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q   <= 1'b0;
      credit_q <= '0;
    end else begin
      credit_q <= credit_d;
      if (aw_in) begin
        full_q <= 1'b1;
      end else if (aw_out) begin
        full_q <= 1'b0;
      end
    end
  end

  // Address payload
  always_ff @(posedge clk_i) begin
    if (aw_in) begin
      id_q   <= slv_aw_id_i;
      addr_q <= slv_aw_addr_i;
      len_q  <= slv_aw_len_i;
    end
  end

endmodule

// ==== logic/beat_fifo.sv ====
// W beat FIFO
// Circular buffer of packed W beats with a fill counter.
// The oldest entry is always visible at head_o, so the downstream
// side can look at the last flag before it pops.

module beat_fifo #(
  parameter int unsigned Depth = axi_pack_pkg::BufDepth
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  push_i,
  input  axi_pack_pkg::w_beat_t data_i,
  input  logic                  pop_i,
  output axi_pack_pkg::w_beat_t head_o,
  output logic                  full_o,
  output logic                  empty_o
);

  import axi_pack_pkg::*;

  typedef logic [$clog2(Depth)-1:0]   ptr_t;
  typedef logic [$clog2(Depth+1)-1:0] cnt_t;

  logic [WBeatWidth-1:0] mem_q [Depth];

  ptr_t wr_ptr_q, rd_ptr_q;
  cnt_t count_q;
  logic do_push, do_pop;

  // Requests against a full or empty buffer are dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  assign full_o  = (count_q == cnt_t'(Depth));
  assign empty_o = (count_q == '0);
  assign head_o  = mem_q[rd_ptr_q];

  // Storage, written at the tail
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap explicitly so that any depth works
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_push) begin
        if (wr_ptr_q == ptr_t'(Depth - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + ptr_t'(1);
        end
      end
      if (do_pop) begin
        if (rd_ptr_q == ptr_t'(Depth - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + ptr_t'(1);
        end
      end
    end
  end

  // Fill level, unchanged on a simultaneous push and pop
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (do_push && !do_pop) begin
      count_q <= count_q + cnt_t'(1);
    end else if (do_pop && !do_push) begin
      count_q <= count_q - cnt_t'(1);
    end
  end

endmodule

// ==== common/axi_pack_pkg.sv ====
// AXI4 write burst packer shared definitions
// Bus widths, buffer depth and the vector types that carry a meaning
// across the beat FIFO, the AW holding stage and the release controller

package axi_pack_pkg;

  // Bus widths in bits
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned IdWidth   = 4;

  // Number of W beats the packing buffer holds
  localparam int unsigned BufDepth = 8;

  // Payload of one buffered W beat: data, strobes and last
  localparam int unsigned WBeatWidth = DataWidth + DataWidth / 8 + 1;

  // Write address
  typedef logic [AddrWidth-1:0] addr_t;

  // Write data and byte strobes
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [DataWidth/8-1:0] strb_t;

  // Transaction id
  typedef logic [IdWidth-1:0] id_t;

  // Burst length minus one, as on the AXI bus
  typedef logic [7:0] len_t;

  // Write response code
  typedef logic [1:0] resp_t;

  // Packed W beat, data in the upper bits and last in bit 0
  typedef logic [WBeatWidth-1:0] w_beat_t;

  // Counts from 0 up to BufDepth
  // Used for complete bursts in the buffer and for AW credits
  typedef logic [$clog2(BufDepth+1)-1:0] buf_cnt_t;

endpackage
